/* vchess_cfg.svh */
`ifndef VCHESS_CFG_SVH
`define VCHESS_CFG_SVH

// Board geometry
`define VCHESS_SQUARES     64
`define VCHESS_ROWS        8    // Rows per board and squares per row
`define VCHESS_PIECE_BITS  4

// Signed material score width
`define VCHESS_EVAL_BITS   22

// King and empty squares count nothing
`define VCHESS_VAL_PAWN    100
`define VCHESS_VAL_KNIGHT  320
`define VCHESS_VAL_BISHOP  330
`define VCHESS_VAL_ROOK    500
`define VCHESS_VAL_QUEEN   900

// APB register map
`define VCHESS_ADDR_BITS     12
`define VCHESS_ADDR_CTRL     12'h000   // Bit 0 starts an evaluation
`define VCHESS_ADDR_STATUS   12'h004   // Bit 0 busy, bit 1 done
`define VCHESS_ADDR_EVAL     12'h008   // Sign-extended score
`define VCHESS_ADDR_SQ_BASE  12'h100   // One word per square up to 0x1FC
`define VCHESS_ADDR_SQ_MASK  12'hF03   // Keeps window bits and byte offset

`endif

/* vchess_pkg.sv */
`default_nettype none

package vchess_pkg;

`include "vchess_cfg.svh"

   // Low three bits of a square code
   typedef enum logic [2:0]
   {
      KIND_EMPTY   = 3'd0,
      KIND_PAWN    = 3'd1,
      KIND_KNIGHT  = 3'd2,
      KIND_BISHOP  = 3'd3,
      KIND_ROOK    = 3'd4,
      KIND_QUEEN   = 3'd5,
      KIND_KING    = 3'd6,
      KIND_INVALID = 3'd7   // Never stored on the board
   } piece_kind_e;

   // A square code seen as a raw nibble or as colour plus kind
   typedef union packed
   {
      logic [`VCHESS_PIECE_BITS-1:0] raw;
      struct packed
      {
         logic        black;   // Set for black pieces
         piece_kind_e kind;
      } pc;
   } piece_u;

   // Squares of one rank with file a in element 0
   typedef piece_u [`VCHESS_ROWS-1:0] row_t;

   // White minus black material
   typedef logic signed [`VCHESS_EVAL_BITS-1:0] score_t;

endpackage

`default_nettype wire

/* vchess_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vchess_cfg.svh"

module vchess_regs
(
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic [`VCHESS_ADDR_BITS-1:0] paddr,
   input  wire logic                         psel,
   input  wire logic                         penable,
   input  wire logic                         pwrite,
   input  wire logic [31:0]                  pwdata,
   input  wire vchess_pkg::piece_u           sq_rdata,
   input  wire logic                         busy,
   input  wire logic                         done,
   input  wire vchess_pkg::score_t           score,
   output logic [31:0]                       prdata,
   output logic                              pready,
   output logic                              pslverr,
   output logic                              sq_wr,
   output logic [5:0]                        sq_addr,
   output vchess_pkg::piece_u                sq_wdata,
   output logic                              start
);

   logic        setup;
   logic        access;
   logic        is_ctrl;
   logic        is_status;
   logic        is_eval;
   logic        is_sq;
   logic        mapped;
   logic        bad_write;
   logic [31:0] rd_mux;

   assign pready = 1'b1;   // Zero wait states

   assign setup  = psel && !penable;
   assign access = psel && penable && pready;

   assign is_ctrl   = (paddr == `VCHESS_ADDR_CTRL);
   assign is_status = (paddr == `VCHESS_ADDR_STATUS);
   assign is_eval   = (paddr == `VCHESS_ADDR_EVAL);
   assign is_sq     = ((paddr & `VCHESS_ADDR_SQ_MASK) == `VCHESS_ADDR_SQ_BASE);
   assign mapped    = is_ctrl || is_status || is_eval || is_sq;

   // Word offset inside the square window is the square index
   assign sq_addr      = paddr[7:2];
   assign sq_wdata.raw = pwdata[`VCHESS_PIECE_BITS-1:0];

   // Square writes are refused for kind 7 or while an evaluation runs.
   // A start already in flight counts as busy.
   always_comb
   begin
      bad_write = 1'b0;
      if (pwrite)
      begin
         if (is_status || is_eval)
            bad_write = 1'b1;               // Read-only registers
         else if (is_sq)
            bad_write = (sq_wdata.raw[2:0] == 3'b111) || busy || start;
      end
   end

   always_comb
   begin
      rd_mux = '0;
      if (is_status)
         rd_mux = {30'd0, done, busy};
      else if (is_eval)
         rd_mux = {{(32-`VCHESS_EVAL_BITS){score[`VCHESS_EVAL_BITS-1]}}, score};
      else if (is_sq)
         rd_mux = {{(32-`VCHESS_PIECE_BITS){1'b0}}, sq_rdata.raw};
   end

   // Response is captured in the setup phase and held through the access phase
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         prdata  <= '0;
         pslverr <= 1'b0;
         start   <= 1'b0;
      end
      else
      begin
         start <= access && pwrite && is_ctrl && pwdata[0];
         if (setup)
         begin
            pslverr <= !mapped || bad_write;
            prdata  <= (pwrite || !mapped) ? 32'd0 : rd_mux;
         end
         else if (access)
         begin
            pslverr <= 1'b0;   // Transfer done
            prdata  <= '0;
         end
      end
   end

   // The registered error also gates the board write
   assign sq_wr = access && pwrite && is_sq && !pslverr;

   a_no_write_busy: assert property (@(posedge clk) disable iff (rst) sq_wr |-> !busy)
      else $error("square write reached the board while the evaluator was busy");

   a_start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
      else $error("start held for more than one cycle");

endmodule

`default_nettype wire

/* vchess_board.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vchess_cfg.svh"

module vchess_board
(
   input  wire logic         clk,
   input  wire logic         rst,
   input  wire logic         sq_wr,
   input  wire logic [5:0]   sq_addr,
   input  wire vchess_pkg::piece_u sq_wdata,
   input  wire logic [2:0]   row_addr,
   output vchess_pkg::piece_u sq_rdata,
   output vchess_pkg::row_t  row_data
);

   vchess_pkg::piece_u squares [`VCHESS_SQUARES];

   // Standard opening setup with white on ranks 0 and 1
   function automatic vchess_pkg::piece_u start_piece(input int idx);
      vchess_pkg::piece_u p;
      int rank;
      int file;
      rank = idx / `VCHESS_ROWS;
      file = idx % `VCHESS_ROWS;
      p.pc.black = (rank >= 6);
      case (rank)
         1, 6:
            p.pc.kind = vchess_pkg::KIND_PAWN;
         0, 7:
            case (file)
               0, 7:    p.pc.kind = vchess_pkg::KIND_ROOK;
               1, 6:    p.pc.kind = vchess_pkg::KIND_KNIGHT;
               2, 5:    p.pc.kind = vchess_pkg::KIND_BISHOP;
               3:       p.pc.kind = vchess_pkg::KIND_QUEEN;
               default: p.pc.kind = vchess_pkg::KIND_KING;
            endcase
         default:
            p.pc.kind = vchess_pkg::KIND_EMPTY;
      endcase
      return p;
   endfunction

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < `VCHESS_SQUARES; i++)
            squares[i] <= start_piece(i);
      end
      else if (sq_wr)
         squares[sq_addr] <= sq_wdata;
   end

   assign sq_rdata = squares[sq_addr];   // Host read without latency

   // Evaluator row port with one cycle of latency
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `VCHESS_ROWS; i++)
         row_data[i] <= squares[row_addr * `VCHESS_ROWS + i];
   end

   a_legal_kind: assert property (@(posedge clk) disable iff (rst)
      sq_wr |-> sq_wdata.pc.kind != vchess_pkg::KIND_INVALID)
      else $error("invalid piece kind written to square %0d", sq_addr);

endmodule

`default_nettype wire

/* vchess_eval.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vchess_cfg.svh"

module vchess_eval
(
   input  wire logic          clk,
   input  wire logic          rst,
   input  wire logic          start,
   input  wire logic          clear,
   input  wire vchess_pkg::row_t row_data,
   output logic [2:0]         row_addr,
   output logic               busy,
   output logic               done,
   output vchess_pkg::score_t score
);

   localparam logic [3:0] LAST_STEP = 4'd8;   // Row 7 lands here
   localparam int SCORE_MAX = 8 * (`VCHESS_VAL_PAWN + `VCHESS_VAL_KNIGHT +
                                   `VCHESS_VAL_BISHOP + `VCHESS_VAL_ROOK +
                                   `VCHESS_VAL_QUEEN);

   logic [3:0]         step;
   vchess_pkg::score_t acc;
   vchess_pkg::score_t row_sum;

   function automatic vchess_pkg::score_t piece_value(input vchess_pkg::piece_kind_e kind);
      vchess_pkg::score_t v;
      case (kind)
         vchess_pkg::KIND_PAWN:   v = `VCHESS_VAL_PAWN;
         vchess_pkg::KIND_KNIGHT: v = `VCHESS_VAL_KNIGHT;
         vchess_pkg::KIND_BISHOP: v = `VCHESS_VAL_BISHOP;
         vchess_pkg::KIND_ROOK:   v = `VCHESS_VAL_ROOK;
         vchess_pkg::KIND_QUEEN:  v = `VCHESS_VAL_QUEEN;
         default:                 v = '0;   // Empty, king
      endcase
      return v;
   endfunction

   // Material of the row that arrived this cycle
   always_comb
   begin
      row_sum = '0;
      for (int i = 0; i < `VCHESS_ROWS; i++)
      begin
         if (row_data[i].pc.black)
            row_sum = row_sum - piece_value(row_data[i].pc.kind);
         else
            row_sum = row_sum + piece_value(row_data[i].pc.kind);
      end
   end

   // Step n addresses row n while row n-1 is summed
   assign row_addr = step[2:0];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy  <= 1'b0;
         done  <= 1'b0;
         step  <= '0;
         score <= '0;
      end
      else if (busy)
      begin
         step <= step + 4'd1;
         if (step == LAST_STEP)
         begin
            busy  <= 1'b0;
            done  <= 1'b1;
            score <= acc + row_sum;
         end
      end
      else if (start)
      begin
         busy <= 1'b1;
         done <= 1'b0;   // Old result goes stale
         step <= '0;
      end
      else if (clear)
         done <= 1'b0;   // Board changed
   end

   always_ff @(posedge clk)
   begin
      if (!busy && start)
         acc <= '0;
      else if (busy && step != 4'd0)
         acc <= acc + row_sum;   // Nothing valid on the row port at step 0
   end

   a_busy_done: assert property (@(posedge clk) disable iff (rst) !(busy && done))
      else $error("busy and done both high");

   a_score_range: assert property (@(posedge clk) disable iff (rst)
      (score <= SCORE_MAX) && (score >= -SCORE_MAX))
      else $error("score %0d outside material range", score);

endmodule

`default_nettype wire

/* vchess_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vchess_cfg.svh"

module vchess_top
(
   input  wire logic                         clk,
   input  wire logic                         rst,
   input  wire logic [`VCHESS_ADDR_BITS-1:0] paddr,
   input  wire logic                         psel,
   input  wire logic                         penable,
   input  wire logic                         pwrite,
   input  wire logic [31:0]                  pwdata,
   output logic [31:0]                       prdata,
   output logic                              pready,
   output logic                              pslverr
);

   logic               sq_wr;
   logic [5:0]         sq_addr;
   vchess_pkg::piece_u sq_wdata;
   vchess_pkg::piece_u sq_rdata;
   logic               start;
   logic [2:0]         row_addr;
   vchess_pkg::row_t   row_data;
   logic               busy;
   logic               done;
   vchess_pkg::score_t score;

   vchess_regs u_regs
   (
      .clk      (clk),
      .rst      (rst),
      .paddr    (paddr),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .pwdata   (pwdata),
      .sq_rdata (sq_rdata),
      .busy     (busy),
      .done     (done),
      .score    (score),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .sq_wr    (sq_wr),
      .sq_addr  (sq_addr),
      .sq_wdata (sq_wdata),
      .start    (start)
   );

   vchess_board u_board
   (
      .clk      (clk),
      .rst      (rst),
      .sq_wr    (sq_wr),
      .sq_addr  (sq_addr),
      .sq_wdata (sq_wdata),
      .row_addr (row_addr),
      .sq_rdata (sq_rdata),
      .row_data (row_data)
   );

   vchess_eval u_eval
   (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .clear    (sq_wr),   // Any accepted board write drops done
      .row_data (row_data),
      .row_addr (row_addr),
      .busy     (busy),
      .done     (done),
      .score    (score)
   );

endmodule

`default_nettype wire

/* tb_vchess.sv */
`timescale 1ns/10ps
`include "vchess_cfg.svh"
`default_nettype none

module tb_vchess;

   localparam int CLK_PERIOD      = 10;
   localparam int WATCHDOG_CYCLES = 6 * 2000;   // Six tests of up to 2000 cycles
   localparam int POLL_LIMIT      = 50;
   // Rook, knight, bishop, queen, king, bishop, knight, rook with file a lowest
   localparam logic [23:0] BACK_RANK = {3'd4, 3'd2, 3'd3, 3'd6, 3'd5, 3'd3, 3'd2, 3'd4};
   localparam int PIECE_VALUE [8] = '{0, `VCHESS_VAL_PAWN, `VCHESS_VAL_KNIGHT,
      `VCHESS_VAL_BISHOP, `VCHESS_VAL_ROOK, `VCHESS_VAL_QUEEN, 0, 0};

   logic                         clk = 1'b0;
   logic                         rst;
   logic [`VCHESS_ADDR_BITS-1:0] paddr;
   logic                         psel;
   logic                         penable;
   logic                         pwrite;
   logic [31:0]                  pwdata;
   logic [31:0]                  prdata;
   logic                         pready;
   logic                         pslverr;

   logic        chk_data;                   // Compare prdata in this transfer
   logic [31:0] exp_data;
   logic        exp_err;
   logic [31:0] rd_data;                    // Captured in the access phase
   logic [31:0] rng_state = 32'd36;
   logic [3:0]  model_board [`VCHESS_SQUARES];
   logic [3:0]  code;
   int          sq;
   int          error_count = 0;
   int          test_count  = 0;
   int          fail_count  = 0;
   int          test_errors = 0;

   vchess_top u_vchess_top (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   a_pready: assert property (@(posedge clk) disable iff (rst)
      (psel && penable) |-> pready)
      else
      begin
         error_count++;
         $display("error %0t pready at 0x%03h expected 1 got %0b", $time,
                  $sampled(paddr), $sampled(pready));
      end

   a_slverr: assert property (@(posedge clk) disable iff (rst)
      (psel && penable) |-> (pslverr == exp_err))
      else
      begin
         error_count++;
         $display("error %0t pslverr at 0x%03h expected %0b got %0b", $time,
                  $sampled(paddr), $sampled(exp_err), $sampled(pslverr));
      end

   a_rdata: assert property (@(posedge clk) disable iff (rst)
      (psel && penable && chk_data) |-> (prdata == exp_data))
      else
      begin
         error_count++;
         $display("error %0t prdata at 0x%03h expected 0x%08h got 0x%08h", $time,
                  $sampled(paddr), $sampled(exp_data), $sampled(prdata));
      end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [3:0] random_piece();
      logic [31:0] r;
      r = next_random();
      return {r[31], 3'(r[15:0] % 7)};   // Kind 0 to 6 in either colour
   endfunction

   function automatic logic [3:0] start_piece_code(input int idx);
      logic [2:0] kind;
      case (idx / 8)
         0, 7:    kind = BACK_RANK[(idx % 8) * 3 +: 3];
         1, 6:    kind = 3'd1;
         default: kind = 3'd0;
      endcase
      return {idx >= 48, kind};   // Black owns ranks 6 and 7
   endfunction

   function automatic int material_score();
      int total;
      total = 0;
      for (int i = 0; i < `VCHESS_SQUARES; i++)
      begin
         if (model_board[i][3])
            total -= PIECE_VALUE[model_board[i][2:0]];
         else
            total += PIECE_VALUE[model_board[i][2:0]];
      end
      return total;
   endfunction

   function automatic logic [11:0] sq_address(input int idx);
      return `VCHESS_ADDR_SQ_BASE + 12'(idx * 4);
   endfunction

   task automatic bus_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                             input logic check, input logic [31:0] exp_rdata,
                             input logic exp_slverr);
      @(posedge clk);
      psel     <= 1'b1;   // Setup phase
      penable  <= 1'b0;
      pwrite   <= wr;
      paddr    <= addr;
      pwdata   <= wdata;
      chk_data <= check;
      exp_data <= exp_rdata;
      exp_err  <= exp_slverr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      rd_data = prdata;
      @(posedge clk);
      psel     <= 1'b0;
      penable  <= 1'b0;
      chk_data <= 1'b0;
   endtask

   task automatic check_board();
      for (int i = 0; i < `VCHESS_SQUARES; i++)
         bus_access(1'b0, sq_address(i), 32'd0, 1'b1, {28'd0, model_board[i]}, 1'b0);
   endtask

   // Poll STATUS until done with busy low, then check the score
   task automatic wait_for_result();
      int polls;
      polls   = 0;
      rd_data = '0;
      while (rd_data[1:0] != 2'b10 && polls < POLL_LIMIT)
      begin
         bus_access(1'b0, `VCHESS_ADDR_STATUS, 32'd0, 1'b0, 32'd0, 1'b0);
         polls++;
      end
      if (rd_data[1:0] != 2'b10)
      begin
         error_count++;
         $display("evaluation did not finish within %0d status polls", POLL_LIMIT);
      end
      bus_access(1'b0, `VCHESS_ADDR_STATUS, 32'd0, 1'b1, 32'd2, 1'b0);
      bus_access(1'b0, `VCHESS_ADDR_EVAL, 32'd0, 1'b1, 32'(material_score()), 1'b0);
   endtask

   task automatic end_test(input string name);
      @(negedge clk);   // Assertion actions of the last edge have run
      test_count++;
      if (error_count != test_errors)
         fail_count++;
      $display("test %0d %s: %s", test_count, name,
               (error_count == test_errors) ? "passed" : "failed");
      test_errors = error_count;
   endtask

   initial
   begin
      rst      = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      chk_data = 1'b0;
      exp_data = '0;
      exp_err  = 1'b0;
      for (int i = 0; i < `VCHESS_SQUARES; i++)
         model_board[i] = start_piece_code(i);
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      check_board();
      bus_access(1'b0, `VCHESS_ADDR_STATUS, 32'd0, 1'b1, 32'd0, 1'b0);
      bus_access(1'b1, `VCHESS_ADDR_CTRL, 32'd1, 1'b0, 32'd0, 1'b0);
      wait_for_result();   // Balanced material
      end_test("reset state");

      repeat (40)
      begin
         sq   = next_random() % `VCHESS_SQUARES;
         code = random_piece();
         bus_access(1'b1, sq_address(sq), {28'd0, code}, 1'b0, 32'd0, 1'b0);
         model_board[sq] = code;
         bus_access(1'b0, sq_address(sq), 32'd0, 1'b1, {28'd0, code}, 1'b0);
      end
      end_test("random square writes");

      for (int board = 0; board < 3; board++)
      begin
         for (int i = 0; i < `VCHESS_SQUARES; i++)
         begin
            code = (board == 2) ? {1'b1, 3'(i % 4)} : random_piece();   // Last one all black
            bus_access(1'b1, sq_address(i), {28'd0, code}, 1'b0, 32'd0, 1'b0);
            model_board[i] = code;
         end
         bus_access(1'b1, `VCHESS_ADDR_CTRL, 32'd1, 1'b0, 32'd0, 1'b0);
         wait_for_result();
      end
      end_test("board evaluation");

      sq = next_random() % `VCHESS_SQUARES;
      bus_access(1'b1, sq_address(sq), 32'hF, 1'b0, 32'd0, 1'b1);   // Kind 7
      bus_access(1'b1, `VCHESS_ADDR_STATUS, 32'h3, 1'b0, 32'd0, 1'b1);
      bus_access(1'b1, `VCHESS_ADDR_EVAL, 32'h1, 1'b0, 32'd0, 1'b1);
      bus_access(1'b0, 12'h020, 32'd0, 1'b1, 32'd0, 1'b1);         // Unmapped
      check_board();
      end_test("refused accesses");

      sq = next_random() % `VCHESS_SQUARES;
      bus_access(1'b1, `VCHESS_ADDR_CTRL, 32'd1, 1'b0, 32'd0, 1'b0);
      bus_access(1'b0, `VCHESS_ADDR_STATUS, 32'd0, 1'b1, 32'd1, 1'b0);
      bus_access(1'b1, `VCHESS_ADDR_CTRL, 32'd1, 1'b0, 32'd0, 1'b0);   // Ignored restart
      bus_access(1'b1, sq_address(sq), {28'd0, ~model_board[sq][3], model_board[sq][2:0]},
                 1'b0, 32'd0, 1'b1);
      wait_for_result();
      check_board();
      end_test("access while busy");

      sq   = next_random() % `VCHESS_SQUARES;
      code = (model_board[sq][2:0] == 3'd5) ? 4'd1 : 4'd5;   // Always a new piece
      bus_access(1'b0, `VCHESS_ADDR_STATUS, 32'd0, 1'b1, 32'd2, 1'b0);
      bus_access(1'b1, sq_address(sq), {28'd0, code}, 1'b0, 32'd0, 1'b0);
      model_board[sq] = code;
      bus_access(1'b0, `VCHESS_ADDR_STATUS, 32'd0, 1'b1, 32'd0, 1'b0);
      bus_access(1'b1, `VCHESS_ADDR_CTRL, 32'd1, 1'b0, 32'd0, 1'b0);
      wait_for_result();
      end_test("done cleared by board write");

      $display("%0d tests, %0d passed, %0d failed, %0d errors", test_count,
               test_count - fail_count, fail_count, error_count);
      if (error_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
vchess_pkg.sv
vchess_regs.sv
vchess_board.sv
vchess_eval.sv
vchess_top.sv
tb_vchess.sv
